// File: design/etx_config.svh
`ifndef ETX_CONFIG_SVH
`define ETX_CONFIG_SVH

// Packet width in bits, matches etx_pkg::packet_t
`define ETX_PW         104

`define ETX_FIFO_DEPTH 4        // Entries per channel queue
`define ETX_NCHAN      3        // rr, wr, rd

// Core ID, compared with dstaddr[31:20]
`define ETX_ID         12'h810

`endif

// File: design/etx_pkg.sv
package etx_pkg;

   // Mesh packet, MSB first
   typedef struct packed {
      logic [31:0] srcaddr;   // Return address for reads
      logic [31:0] data;      // Write data or read-back value
      logic [31:0] dstaddr;   // Target, top 12 bits are the core ID
      logic [4:0]  ctrlmode;  // Low nibble can be overridden
      logic [1:0]  datamode;  // 2'b11 is a double word
      logic        write;     // 0 for read requests
   } packet_t;

   // Index of each request channel, also its priority order
   typedef enum logic [1:0] {
      CH_RR = 2'd0,           // Read responses, highest
      CH_WR = 2'd1,           // Posted writes
      CH_RD = 2'd2            // Read requests, lowest
   } chan_e;

   // Register select in dstaddr[3:2]
   typedef enum logic [1:0] {
      REG_CTRL  = 2'd0,       // Enables and ctrlmode override
      REG_REMAP = 2'd1        // Remap pattern and base
   } cfg_reg_e;

endpackage

// File: design/etx_chan_fifo.sv
`timescale 1ns/10ps
`include "etx_config.svh"

module etx_chan_fifo #(
   parameter int DEPTH = `ETX_FIFO_DEPTH              // Queue entries
) (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             in_access,                 // Packet offered
   input  etx_pkg::packet_t in_packet,
   output logic             in_wait,                   // Full level
   output logic             head_valid,
   output etx_pkg::packet_t head_packet,
   input  logic             pop                        // From arbiter
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width
   localparam int CW = $clog2(DEPTH + 1);                // Count width

   logic [`ETX_PW-1:0] mem [DEPTH];                      // Packet storage
   logic [AW-1:0]      wr_ptr;
   logic [AW-1:0]      rd_ptr;
   logic [CW-1:0]      count;                            // Entries held
   logic               push;

   assign push        = in_access & ~in_wait;            // Taken this edge
   assign in_wait     = (count == DEPTH);
   assign head_valid  = (count != 0);
   assign head_packet = mem[rd_ptr];                     // Seen after write edge

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= in_packet;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CW'(push) - CW'(pop);          // Both may happen
      end
   end

   // Arbiter must only pop a queue that shows a head
   a_pop_not_empty: assert property (@(posedge clk) disable iff (!arst_n)
      pop |-> head_valid);

   a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
      count <= DEPTH);

endmodule

// File: design/etx_arbiter.sv
`timescale 1ns/10ps
`include "etx_config.svh"

module etx_arbiter (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic [`ETX_NCHAN-1:0]  chan_valid,         // Queue heads present
   input  etx_pkg::packet_t       chan_packet [`ETX_NCHAN],
   input  logic                   link_rd_wait,       // Blocks read requests
   input  logic                   link_wr_wait,       // Blocks writes and responses
   input  logic                   pipe_stall,
   input  logic                   cfg_busy,           // Read-back pending
   output logic [`ETX_NCHAN-1:0]  chan_pop,
   output logic                   sel_access,
   output etx_pkg::packet_t       sel_packet,
   output logic                   sel_rr              // Winner is a read response
);

   import etx_pkg::*;

   logic [`ETX_NCHAN-1:0] head_cfg;                   // Head targets this core
   logic [`ETX_NCHAN-1:0] eligible;
   logic                  blocked;

   assign blocked = pipe_stall | cfg_busy;            // Holds every channel

   always_comb begin
      for (int i = 0; i < `ETX_NCHAN; i++) begin
         head_cfg[i] = (chan_packet[i].dstaddr[31:20] == `ETX_ID);
         // Config packets never reach the link, so link waits do not apply
         eligible[i] = chan_valid[i] &
                       (head_cfg[i] | ~((i == int'(CH_RD)) ? link_rd_wait : link_wr_wait));
      end
   end

   // Lowest index wins, rr before wr before rd
   assign chan_pop   = blocked ? '0 : eligible & (~eligible + 1'b1);
   assign sel_access = |chan_pop;
   assign sel_rr     = chan_pop[CH_RR];

   always_comb begin
      sel_packet = chan_packet[CH_RR];                  // Default when idle
      for (int i = 0; i < `ETX_NCHAN; i++) begin
         if (chan_pop[i]) begin
            sel_packet = chan_packet[i];
         end
      end
   end

   a_pop_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(chan_pop));

endmodule

// File: design/etx_cfg.sv
`timescale 1ns/10ps
`include "etx_config.svh"

module etx_cfg (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             sel_access,          // Granted packet
   input  etx_pkg::packet_t sel_packet,
   input  logic             sel_rr,
   output logic             fwd_access,          // Link-bound packet
   output etx_pkg::packet_t fwd_packet,
   output logic             fwd_rr,
   output logic             tx_enable,
   output logic             remap_enable,
   output logic [7:0]       remap_pattern,       // Matched against dstaddr[31:24]
   output logic [7:0]       remap_base,
   output logic             ctrlmode_bypass,     // Override enable
   output logic [3:0]       ctrlmode,            // Override value
   output logic             etx_cfg_access,      // Read-back response
   output etx_pkg::packet_t etx_cfg_packet,
   input  logic             etx_cfg_wait
);

   import etx_pkg::*;

   logic        id_match;
   logic        cfg_wr;
   logic        cfg_rd;
   cfg_reg_e    reg_sel;
   logic [31:0] rd_data;
   packet_t     rsp_packet;

   assign id_match = (sel_packet.dstaddr[31:20] == `ETX_ID);
   assign cfg_wr   = sel_access & id_match & sel_packet.write;
   assign cfg_rd   = sel_access & id_match & ~sel_packet.write;
   assign reg_sel  = cfg_reg_e'(sel_packet.dstaddr[3:2]);

   // Everything else passes on in the same cycle
   assign fwd_access = sel_access & ~id_match;
   assign fwd_packet = sel_packet;
   assign fwd_rr     = sel_rr;

   always_comb begin
      case (reg_sel)
         REG_CTRL:  rd_data = {23'd0, ctrlmode_bypass, ctrlmode, 2'b00,
                               remap_enable, tx_enable};
         REG_REMAP: rd_data = {16'd0, remap_base, remap_pattern};
         default:   rd_data = 32'd0;             // Unmapped offsets
      endcase
   end

   always_comb begin
      rsp_packet         = sel_packet;
      rsp_packet.write   = 1'b1;                 // Responses are writes
      rsp_packet.dstaddr = sel_packet.srcaddr;   // Back to the requester
      rsp_packet.srcaddr = sel_packet.dstaddr;
      rsp_packet.data    = rd_data;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_enable       <= 1'b0;
         remap_enable    <= 1'b0;
         ctrlmode_bypass <= 1'b0;
         ctrlmode        <= '0;
         remap_pattern   <= '0;
         remap_base      <= '0;
      end else if (cfg_wr) begin
         case (reg_sel)
            REG_CTRL: begin
               tx_enable       <= sel_packet.data[0];
               remap_enable    <= sel_packet.data[1];
               ctrlmode        <= sel_packet.data[7:4];
               ctrlmode_bypass <= sel_packet.data[8];
            end
            REG_REMAP: begin
               remap_pattern <= sel_packet.data[7:0];
               remap_base    <= sel_packet.data[15:8];
            end
            default: ;                           // Ignored
         endcase
      end
   end

   // Response held until the receiver drops its wait
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         etx_cfg_access <= 1'b0;
      end else if (cfg_rd) begin
         etx_cfg_access <= 1'b1;
      end else if (!etx_cfg_wait) begin
         etx_cfg_access <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (cfg_rd) begin
         etx_cfg_packet <= rsp_packet;
      end
   end

   a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
      etx_cfg_access && etx_cfg_wait |=> etx_cfg_access && $stable(etx_cfg_packet));

endmodule

// File: design/etx_remap.sv
`timescale 1ns/10ps

module etx_remap (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             fwd_access,
   input  etx_pkg::packet_t fwd_packet,
   input  logic             fwd_rr,              // Responses keep their address
   input  logic             remap_enable,
   input  logic [7:0]       remap_pattern,
   input  logic [7:0]       remap_base,
   input  logic             pipe_stall,          // Hold both registers
   output logic             rm_access,
   output etx_pkg::packet_t rm_packet
);

   import etx_pkg::*;

   packet_t remapped;

   always_comb begin
      remapped = fwd_packet;
      if (remap_enable && !fwd_rr &&
          (fwd_packet.dstaddr[31:24] == remap_pattern)) begin
         remapped.dstaddr[31:24] = remap_base;   // Swap top byte only
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rm_access <= 1'b0;
      end else if (!pipe_stall) begin
         rm_access <= fwd_access;
      end
   end

   always_ff @(posedge clk) begin
      if (!pipe_stall) begin
         rm_packet <= remapped;
      end
   end

endmodule

// File: design/etx_protocol.sv
`timescale 1ns/10ps

module etx_protocol (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             rm_access,
   input  etx_pkg::packet_t rm_packet,
   input  logic             tx_enable,
   input  logic             ctrlmode_bypass,
   input  logic [3:0]       ctrlmode,
   input  logic             tx_io_wait,          // Link cannot take output
   input  logic             tx_rd_wait,
   input  logic             tx_wr_wait,
   output logic             tx_access,
   output logic             tx_burst,
   output etx_pkg::packet_t tx_packet,
   output logic             link_rd_wait,        // To arbiter
   output logic             link_wr_wait,
   output logic             pipe_stall
);

   import etx_pkg::*;

   packet_t out_packet;
   logic    rm_dw_write;                         // Incoming is a double-word write
   logic    tx_dw_write;
   logic    burst_next;

   assign link_rd_wait = tx_rd_wait | tx_io_wait | ~tx_enable;
   assign link_wr_wait = tx_wr_wait | tx_io_wait | ~tx_enable;
   // Disabled link parks any packet already in the remap register
   assign pipe_stall   = tx_io_wait | (~tx_enable & rm_access);

   always_comb begin
      out_packet = rm_packet;
      if (ctrlmode_bypass) begin
         out_packet.ctrlmode[3:0] = ctrlmode;
      end
   end

   assign rm_dw_write = rm_packet.write & (rm_packet.datamode == 2'b11);
   assign tx_dw_write = tx_packet.write & (tx_packet.datamode == 2'b11);
   // tx_access here is the previous cycle's output
   assign burst_next  = rm_dw_write & tx_access & tx_dw_write &
                        (rm_packet.dstaddr == tx_packet.dstaddr + 32'd8);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tx_access <= 1'b0;
         tx_burst  <= 1'b0;
      end else if (!pipe_stall) begin
         tx_access <= rm_access & tx_enable;
         tx_burst  <= rm_access & tx_enable & burst_next;
      end
   end

   always_ff @(posedge clk) begin
      if (!pipe_stall) begin
         tx_packet <= out_packet;
      end
   end

   // Link may sample late, output must not move under it
   a_tx_hold: assert property (@(posedge clk) disable iff (!arst_n)
      tx_access && tx_io_wait |=> tx_access && $stable(tx_packet));

endmodule

// File: design/etx_core.sv
`timescale 1ns/10ps
`include "etx_config.svh"

module etx_core (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             txwr_access,         // Posted writes
   input  etx_pkg::packet_t txwr_packet,
   output logic             txwr_wait,
   input  logic             txrd_access,         // Read requests
   input  etx_pkg::packet_t txrd_packet,
   output logic             txrd_wait,
   input  logic             txrr_access,         // Read responses
   input  etx_pkg::packet_t txrr_packet,
   output logic             txrr_wait,
   output logic             tx_access,           // Link side
   output logic             tx_burst,
   output etx_pkg::packet_t tx_packet,
   input  logic             tx_io_wait,
   input  logic             tx_rd_wait,
   input  logic             tx_wr_wait,
   output logic             etx_cfg_access,      // Register read-back
   output etx_pkg::packet_t etx_cfg_packet,
   input  logic             etx_cfg_wait
);

   import etx_pkg::*;

   logic [`ETX_NCHAN-1:0] ch_access;
   logic [`ETX_NCHAN-1:0] ch_wait;
   logic [`ETX_NCHAN-1:0] ch_valid;
   logic [`ETX_NCHAN-1:0] ch_pop;
   packet_t               ch_packet [`ETX_NCHAN];
   packet_t               ch_head   [`ETX_NCHAN];
   logic                  sel_access, sel_rr, fwd_access, fwd_rr, rm_access;
   packet_t               sel_packet, fwd_packet, rm_packet;
   logic                  tx_enable, remap_enable, ctrlmode_bypass;
   logic [7:0]            remap_pattern, remap_base;
   logic [3:0]            ctrlmode;
   logic                  link_rd_wait, link_wr_wait, pipe_stall;

   // Channel slots in priority order
   assign ch_access[CH_RR] = txrr_access;
   assign ch_packet[CH_RR] = txrr_packet;
   assign ch_access[CH_WR] = txwr_access;
   assign ch_packet[CH_WR] = txwr_packet;
   assign ch_access[CH_RD] = txrd_access;
   assign ch_packet[CH_RD] = txrd_packet;
   assign txrr_wait        = ch_wait[CH_RR];
   assign txwr_wait        = ch_wait[CH_WR];
   assign txrd_wait        = ch_wait[CH_RD];

   for (genvar i = 0; i < `ETX_NCHAN; i++) begin : g_chan
      etx_chan_fifo u_fifo (.clk(clk), .arst_n(arst_n), .in_access(ch_access[i]),
         .in_packet(ch_packet[i]), .in_wait(ch_wait[i]), .head_valid(ch_valid[i]),
         .head_packet(ch_head[i]), .pop(ch_pop[i]));
   end

   etx_arbiter etx_arbiter (.clk(clk), .arst_n(arst_n), .chan_valid(ch_valid),
      .chan_packet(ch_head), .link_rd_wait(link_rd_wait), .link_wr_wait(link_wr_wait),
      .pipe_stall(pipe_stall), .cfg_busy(etx_cfg_access), .chan_pop(ch_pop),
      .sel_access(sel_access), .sel_packet(sel_packet), .sel_rr(sel_rr));

   etx_cfg etx_cfg (.clk(clk), .arst_n(arst_n), .sel_access(sel_access),
      .sel_packet(sel_packet), .sel_rr(sel_rr), .fwd_access(fwd_access),
      .fwd_packet(fwd_packet), .fwd_rr(fwd_rr), .tx_enable(tx_enable),
      .remap_enable(remap_enable), .remap_pattern(remap_pattern),
      .remap_base(remap_base), .ctrlmode_bypass(ctrlmode_bypass), .ctrlmode(ctrlmode),
      .etx_cfg_access(etx_cfg_access), .etx_cfg_packet(etx_cfg_packet),
      .etx_cfg_wait(etx_cfg_wait));

   etx_remap etx_remap (.clk(clk), .arst_n(arst_n), .fwd_access(fwd_access),
      .fwd_packet(fwd_packet), .fwd_rr(fwd_rr), .remap_enable(remap_enable),
      .remap_pattern(remap_pattern), .remap_base(remap_base), .pipe_stall(pipe_stall),
      .rm_access(rm_access), .rm_packet(rm_packet));

   etx_protocol etx_protocol (.clk(clk), .arst_n(arst_n), .rm_access(rm_access),
      .rm_packet(rm_packet), .tx_enable(tx_enable), .ctrlmode_bypass(ctrlmode_bypass),
      .ctrlmode(ctrlmode), .tx_io_wait(tx_io_wait), .tx_rd_wait(tx_rd_wait),
      .tx_wr_wait(tx_wr_wait), .tx_access(tx_access), .tx_burst(tx_burst),
      .tx_packet(tx_packet), .link_rd_wait(link_rd_wait), .link_wr_wait(link_wr_wait),
      .pipe_stall(pipe_stall));

endmodule

// File: verification/etx_checker.sv
`timescale 1ns/10ps
`include "etx_config.svh"

module etx_checker (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  txrr_access,
   input  etx_pkg::packet_t      txrr_packet,
   input  logic                  txrr_wait,
   input  logic                  txwr_access,
   input  etx_pkg::packet_t      txwr_packet,
   input  logic                  txwr_wait,
   input  logic                  txrd_access,
   input  etx_pkg::packet_t      txrd_packet,
   input  logic                  txrd_wait,
   input  logic                  tx_access,
   input  logic                  tx_burst,
   input  etx_pkg::packet_t      tx_packet,
   input  logic                  tx_io_wait,
   input  logic                  tx_rd_wait,
   input  logic                  tx_wr_wait,
   input  logic                  etx_cfg_access,
   input  etx_pkg::packet_t      etx_cfg_packet,
   input  logic                  etx_cfg_wait,
   input  logic [`ETX_NCHAN-1:0] chan_pop,           // Grant inside the DUT
   input  etx_pkg::packet_t      sel_packet,
   output int                    err_cnt,
   output int                    match_cnt,
   output int                    pending             // Expected but not yet seen
);

   import etx_pkg::*;

   packet_t    q_rr[$], q_wr[$], q_rd[$], q_cfg[$];
   logic       tx_en, rm_en, byp;                    // Register shadow
   logic [7:0] pat, base;
   logic [3:0] mode;
   logic       prev_acc;                             // Last consumed link output
   packet_t    prev_pkt;
   logic       held_v;
   packet_t    held;

   // Link packet per the remap and override rules
   function automatic packet_t expected_link_packet(input packet_t p, input logic is_rr);
      packet_t e;
      e = p;
      if (rm_en && !is_rr && p.dstaddr[31:24] == pat) e.dstaddr[31:24] = base;
      if (byp) e.ctrlmode[3:0] = mode;
      return e;
   endfunction

   function automatic logic [31:0] reg_value(input logic [1:0] sel);
      if (sel == 2'd0) return {23'd0, byp, mode, 2'b00, rm_en, tx_en};
      if (sel == 2'd1) return {16'd0, base, pat};
      return 32'd0;
   endfunction

   function automatic logic is_dw(input packet_t p);
      return p.write && p.datamode == 2'b11;
   endfunction

   task automatic take_input(input int ch, input packet_t p);
      packet_t r;
      if (p.dstaddr[31:20] == `ETX_ID) begin
         if (p.write) begin
            if (p.dstaddr[3:2] == 2'd0) begin
               tx_en = p.data[0];
               rm_en = p.data[1];
               mode  = p.data[7:4];
               byp   = p.data[8];
            end else if (p.dstaddr[3:2] == 2'd1) begin
               pat  = p.data[7:0];
               base = p.data[15:8];
            end
         end else begin
            r         = p;                            // Read-back response
            r.write   = 1'b1;
            r.dstaddr = p.srcaddr;
            r.srcaddr = p.dstaddr;
            r.data    = reg_value(p.dstaddr[3:2]);
            q_cfg.push_back(r);
         end
      end else if (ch == 0) q_rr.push_back(expected_link_packet(p, 1'b1));
      else if (ch == 1) q_wr.push_back(expected_link_packet(p, 1'b0));
      else q_rd.push_back(expected_link_packet(p, 1'b0));
   endtask

   always @(posedge clk) begin : check
      packet_t e;
      logic    found;
      logic    exp_burst;
      if (!arst_n) begin
         {tx_en, rm_en, byp, pat, base, mode} = '0;
         prev_acc  = 1'b0;
         held_v    = 1'b0;
         err_cnt   = 0;
         match_cnt = 0;
      end else begin
         if (txrr_access && !txrr_wait) take_input(0, txrr_packet);
         if (txwr_access && !txwr_wait) take_input(1, txwr_packet);
         if (txrd_access && !txrd_wait) take_input(2, txrd_packet);
         if (sel_packet.dstaddr[31:20] != `ETX_ID) begin
            if (chan_pop[CH_RD] && tx_rd_wait) begin
               err_cnt++;
               $display("%0t: read request granted while tx_rd_wait was high", $time);
            end
            if ((chan_pop[CH_WR] || chan_pop[CH_RR]) && tx_wr_wait) begin
               err_cnt++;
               $display("%0t: write granted while tx_wr_wait was high", $time);
            end
         end
         if (tx_access && !tx_en) begin
            err_cnt++;
            $display("%0t: packet left the link with transmit disabled", $time);
         end
         if (!tx_io_wait) begin
            if (tx_access) begin
               found = 1'b1;
               case (tx_packet.srcaddr[1:0])
                  2'd0:    if (q_rr.size() > 0) e = q_rr.pop_front(); else found = 1'b0;
                  2'd1:    if (q_wr.size() > 0) e = q_wr.pop_front(); else found = 1'b0;
                  2'd2:    if (q_rd.size() > 0) e = q_rd.pop_front(); else found = 1'b0;
                  default: found = 1'b0;
               endcase
               if (!found) begin
                  err_cnt++;
                  $display("%0t: unexpected packet on the link, srcaddr %h", $time,
                           tx_packet.srcaddr);
               end else if (tx_packet !== e) begin
                  err_cnt++;
                  $display("Fail %0t tx_packet expected %h actual %h", $time, e, tx_packet);
               end else begin
                  match_cnt++;
               end
               exp_burst = found && prev_acc && is_dw(prev_pkt) && is_dw(e) &&
                           e.dstaddr == prev_pkt.dstaddr + 32'd8;
               if (tx_burst !== exp_burst) begin
                  err_cnt++;
                  $display("Fail %0t tx_burst expected %b actual %b", $time, exp_burst,
                           tx_burst);
               end
            end
            prev_acc = tx_access && found;            // Output consumed this edge
            if (prev_acc) begin
               prev_pkt = e;
            end
         end
         if (etx_cfg_access && etx_cfg_wait) begin
            if (held_v && etx_cfg_packet !== held) begin
               err_cnt++;
               $display("Fail %0t etx_cfg_packet expected %h actual %h", $time, held,
                        etx_cfg_packet);
            end
            held   = etx_cfg_packet;
            held_v = 1'b1;
         end else if (etx_cfg_access) begin
            held_v = 1'b0;
            if (q_cfg.size() == 0) begin
               err_cnt++;
               $display("%0t: configuration response with no read pending", $time);
            end else begin
               e = q_cfg.pop_front();
               if (etx_cfg_packet !== e) begin
                  err_cnt++;
                  $display("Fail %0t etx_cfg_packet expected %h actual %h", $time, e,
                           etx_cfg_packet);
               end else begin
                  match_cnt++;
               end
            end
         end
      end
      pending = q_rr.size() + q_wr.size() + q_rd.size() + q_cfg.size();
   end

endmodule

// File: verification/tb_etx_core.sv
`timescale 1ns/10ps
`include "etx_config.svh"

module tb_etx_core;

   import etx_pkg::*;

   localparam int RAND_PKTS = 40;                     // Per channel in the random phase
   localparam int NUM_PKTS  = 32 + 3 * RAND_PKTS;     // Directed packets plus random phase
   localparam int LIMIT_CYC = NUM_PKTS * 40 + 2000;

   logic        clk;
   logic        arst_n;
   logic        acc [3];                              // Indexed by chan_e
   packet_t     pkt [3];
   logic        wt  [3];
   logic        tx_access, tx_burst, etx_cfg_access;
   packet_t     tx_packet, etx_cfg_packet;
   logic        tx_io_wait, tx_rd_wait, tx_wr_wait, etx_cfg_wait;
   logic [31:0] lfsr;
   logic        rand_on;                              // Random link waits
   int          err_cnt, match_cnt, pending;

   etx_core uut (.clk(clk), .arst_n(arst_n),
      .txwr_access(acc[CH_WR]), .txwr_packet(pkt[CH_WR]), .txwr_wait(wt[CH_WR]),
      .txrd_access(acc[CH_RD]), .txrd_packet(pkt[CH_RD]), .txrd_wait(wt[CH_RD]),
      .txrr_access(acc[CH_RR]), .txrr_packet(pkt[CH_RR]), .txrr_wait(wt[CH_RR]),
      .tx_access(tx_access), .tx_burst(tx_burst), .tx_packet(tx_packet),
      .tx_io_wait(tx_io_wait), .tx_rd_wait(tx_rd_wait), .tx_wr_wait(tx_wr_wait),
      .etx_cfg_access(etx_cfg_access), .etx_cfg_packet(etx_cfg_packet),
      .etx_cfg_wait(etx_cfg_wait));

   etx_checker u_checker (.clk(clk), .arst_n(arst_n),
      .txrr_access(acc[CH_RR]), .txrr_packet(pkt[CH_RR]), .txrr_wait(wt[CH_RR]),
      .txwr_access(acc[CH_WR]), .txwr_packet(pkt[CH_WR]), .txwr_wait(wt[CH_WR]),
      .txrd_access(acc[CH_RD]), .txrd_packet(pkt[CH_RD]), .txrd_wait(wt[CH_RD]),
      .tx_access(tx_access), .tx_burst(tx_burst), .tx_packet(tx_packet),
      .tx_io_wait(tx_io_wait), .tx_rd_wait(tx_rd_wait), .tx_wr_wait(tx_wr_wait),
      .etx_cfg_access(etx_cfg_access), .etx_cfg_packet(etx_cfg_packet),
      .etx_cfg_wait(etx_cfg_wait), .chan_pop(uut.ch_pop), .sel_packet(uut.sel_packet),
      .err_cnt(err_cnt), .match_cnt(match_cnt), .pending(pending));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;                          // 10 ns period
   end

   // Fibonacci LFSR on taps 32 22 2 1 stepping once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [31:0] rand_dst();
      logic [31:0] d;
      d = rand_bits(32);
      if (rand_bits(1)) d[31:24] = 8'h3A;             // Hits the remap pattern
      if (d[31:20] == `ETX_ID) d[31:20] = 12'h000;    // Keep off the config space
      return d;
   endfunction

   function automatic packet_t make_pkt(input int ch, input logic wr, input logic [31:0] dst,
                                        input logic [1:0] dm);
      packet_t     p;
      logic [31:0] r;
      r          = rand_bits(30);
      p.srcaddr  = {r[29:0], 2'(ch)};                 // Channel tag in [1:0]
      p.data     = rand_bits(32);
      p.dstaddr  = dst;
      p.ctrlmode = 5'(rand_bits(5));
      p.datamode = dm;
      p.write    = wr;
      return p;
   endfunction

   // Called at a rising edge and returns at the edge that took the packet
   task automatic send(input int ch, input packet_t p);
      acc[ch] <= 1'b1;
      pkt[ch] <= p;
      @(posedge clk);
      while (wt[ch]) @(posedge clk);
      acc[ch] <= 1'b0;
   endtask

   task automatic cfg_write(input logic [1:0] reg_sel, input logic [31:0] value);
      packet_t p;
      p      = make_pkt(CH_RR, 1'b1, {`ETX_ID, 16'h0, reg_sel, 2'b00}, 2'b10);
      p.data = value;
      send(CH_RR, p);
      @(posedge clk);                                 // Head visible from here
      while (uut.ch_valid[CH_RR]) @(posedge clk);     // Applied at the grant edge
   endtask

   task automatic cfg_read(input logic [1:0] reg_sel, input int hold);
      etx_cfg_wait <= 1'b1;
      send(CH_RR, make_pkt(CH_RR, 1'b0, {`ETX_ID, 16'h0, reg_sel, 2'b00}, 2'b10));
      while (!etx_cfg_access) @(posedge clk);
      repeat (hold) @(posedge clk);                   // Response must stay put
      etx_cfg_wait <= 1'b0;
      @(posedge clk);
      while (etx_cfg_access) @(posedge clk);
   endtask

   task automatic wait_drained();
      @(posedge clk);
      while (pending != 0 || uut.ch_valid != '0) @(posedge clk);
   endtask

   task automatic rand_traffic(input int ch);
      int gap;
      for (int n = 0; n < RAND_PKTS; n++) begin
         gap = rand_bits(2);
         repeat (gap) @(posedge clk);
         send(ch, make_pkt(ch, ch != int'(CH_RD), rand_dst(), 2'(rand_bits(2))));
      end
   endtask

   always @(posedge clk) begin
      if (rand_on) begin
         tx_io_wait <= (rand_bits(2) == 2'd0);        // About one cycle in four
         tx_rd_wait <= (rand_bits(2) == 2'd0);
         tx_wr_wait <= (rand_bits(3) == 3'd0);
      end else begin
         tx_io_wait <= 1'b0;
         tx_rd_wait <= 1'b0;
         tx_wr_wait <= 1'b0;
      end
   end

   initial begin
      lfsr         = 32'h20e3;
      rand_on      = 1'b0;
      arst_n       = 1'b0;
      tx_io_wait   = 1'b0;
      tx_rd_wait   = 1'b0;
      tx_wr_wait   = 1'b0;
      etx_cfg_wait = 1'b0;
      for (int i = 0; i < 3; i++) begin
         acc[i] = 1'b0;
         pkt[i] = '0;
      end
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      // These park in the queues while transmit is off
      for (int i = 0; i < 3; i++) begin
         send(CH_WR, make_pkt(CH_WR, 1'b1, rand_dst(), 2'b10));
         send(CH_RD, make_pkt(CH_RD, 1'b0, rand_dst(), 2'b10));
      end
      repeat (10) @(posedge clk);
      cfg_write(REG_CTRL, 32'h0000_0001);
      wait_drained();
      cfg_write(REG_REMAP, 32'h0000_C53A);            // Pattern 3A and base C5
      cfg_read(REG_REMAP, 4);
      cfg_read(REG_CTRL, 2);
      cfg_write(REG_CTRL, 32'h0000_01A3);             // Remap on with override value A
      cfg_read(REG_CTRL, 3);
      for (int i = 0; i < 2; i++) begin
         send(CH_WR, make_pkt(CH_WR, 1'b1, {8'h3A, 24'(rand_bits(24))}, 2'b10));
         send(CH_RD, make_pkt(CH_RD, 1'b0, {8'h3A, 24'(rand_bits(24))}, 2'b10));
         send(CH_RR, make_pkt(CH_RR, 1'b1, {8'h3A, 24'(rand_bits(24))}, 2'b10));
         send(CH_WR, make_pkt(CH_WR, 1'b1, {8'h77, 24'(rand_bits(24))}, 2'b10));
      end
      wait_drained();
      cfg_write(REG_CTRL, 32'h0000_0001);
      for (int i = 0; i < 6; i++) begin
         send(CH_WR, make_pkt(CH_WR, 1'b1, 32'h2000_0000 + 32'(8 * i), 2'b11));
      end
      send(CH_WR, make_pkt(CH_WR, 1'b1, 32'h2000_0100, 2'b10));  // Single word breaks run
      for (int i = 0; i < 3; i++) begin
         send(CH_WR, make_pkt(CH_WR, 1'b1, 32'h2000_0108 + 32'(8 * i), 2'b11));
      end
      wait_drained();
      cfg_write(REG_CTRL, 32'h0000_0153);             // Remap on with override value 5
      rand_on <= 1'b1;
      fork
         rand_traffic(CH_RR);
         rand_traffic(CH_WR);
         rand_traffic(CH_RD);
      join
      rand_on <= 1'b0;
      wait_drained();
      repeat (2) @(posedge clk);
      if (pending != 0) begin
         $display("%0d expected packets never came out", pending);
      end
      $display("Checks passed: %0d, errors: %0d, missing: %0d", match_cnt, err_cnt, pending);
      if (err_cnt == 0 && pending == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin
      #(LIMIT_CYC * 10);
      $display("Timeout after %0d cycles, the run did not finish", LIMIT_CYC);
      $display("Simulation failed");
      $finish;
   end

endmodule

// File: etx_core.f
+incdir+design
design/etx_pkg.sv
design/etx_chan_fifo.sv
design/etx_arbiter.sv
design/etx_cfg.sv
design/etx_remap.sv
design/etx_protocol.sv
design/etx_core.sv
verification/etx_checker.sv
verification/tb_etx_core.sv
